// File: source/cpuPkg.sv
package cpuPkg;

  localparam int regAddrWidth = 3;
  localparam int opCodeWidth = 5;

  // Instruction set encodings
  typedef enum logic [opCodeWidth-1:0] {
    opNop   = 5'd0,  opSetc  = 5'd1,  opClrc  = 5'd2,  opNot   = 5'd3,
    opInc   = 5'd4,  opDec   = 5'd5,  opOut   = 5'd6,  opIn    = 5'd7,
    opMov   = 5'd8,  opAdd   = 5'd9,  opSub   = 5'd10, opAnd   = 5'd11,
    opOr    = 5'd12, opShl   = 5'd13, opShr   = 5'd14, opPush  = 5'd15,
    opPop   = 5'd16, opLdm   = 5'd17, opLdd   = 5'd18, opStd   = 5'd19,
    // Control transfer, not executed by this core
    opJz    = 5'd20, opJn    = 5'd21, opJc    = 5'd22, opJmp   = 5'd23,
    opCall  = 5'd24, opCall2 = 5'd25, opRet   = 5'd26, opRet2  = 5'd27,
    opRti   = 5'd28, opRti2  = 5'd29, opInt   = 5'd30, opInt2  = 5'd31
  } opCodeT;

  typedef enum logic [3:0] {
    aluAdd     = 4'd0,
    aluSub     = 4'd1,
    aluAnd     = 4'd2,
    aluOr      = 4'd3,
    aluShl     = 4'd4,
    aluShr     = 4'd5,
    aluNot     = 4'd6,
    aluPassImm = 4'd7,
    aluInc     = 4'd8,
    aluDec     = 4'd9,
    aluPassReg = 4'd10
  } aluOpT;

  typedef enum logic [1:0] {
    spHold = 2'd0,
    spPush = 2'd1,
    spPop  = 2'd2
  } spOpT;

  typedef enum logic [1:0] {
    carryAlu   = 2'd0,
    carryClear = 2'd1,
    carrySet   = 2'd3
  } carrySrcT;

endpackage

// File: source/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
  input  cpuPkg::opCodeT   opCode,
  output cpuPkg::aluOpT    aluOp,
  output cpuPkg::spOpT     spOp,
  output cpuPkg::carrySrcT carrySrc,
  output logic             regWrite,
  output logic             memRead,
  output logic             memWrite,
  output logic             memOrReg,
  output logic             updateStatus,
  output logic             immOrReg,
  output logic             isOut,
  output logic             isIn,
  output logic             supported
);

  // ALU operation; passImm forwards the second operand
  always_comb begin
    case (opCode)
      cpuPkg::opNot: aluOp = cpuPkg::aluNot;
      cpuPkg::opInc: aluOp = cpuPkg::aluInc;
      cpuPkg::opDec: aluOp = cpuPkg::aluDec;
      cpuPkg::opAdd: aluOp = cpuPkg::aluAdd;
      cpuPkg::opSub: aluOp = cpuPkg::aluSub;
      cpuPkg::opAnd: aluOp = cpuPkg::aluAnd;
      cpuPkg::opOr:  aluOp = cpuPkg::aluOr;
      cpuPkg::opShl: aluOp = cpuPkg::aluShl;
      cpuPkg::opShr: aluOp = cpuPkg::aluShr;
      cpuPkg::opMov, cpuPkg::opLdm, cpuPkg::opLdd: aluOp = cpuPkg::aluPassImm;
      default:       aluOp = cpuPkg::aluPassReg;
    endcase
  end

  always_comb begin
    // Everything defaults to a no-op
    spOp = cpuPkg::spHold;
    carrySrc = cpuPkg::carryAlu;
    regWrite = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    memOrReg = 1'b1;
    updateStatus = 1'b0;
    immOrReg = 1'b1;
    isOut = 1'b0;
    isIn = 1'b0;
    supported = 1'b1;
    case (opCode)
      cpuPkg::opNop: ;
      cpuPkg::opSetc: begin
        updateStatus = 1'b1;
        carrySrc = cpuPkg::carrySet;
      end
      cpuPkg::opClrc: begin
        updateStatus = 1'b1;
        carrySrc = cpuPkg::carryClear;
      end
      cpuPkg::opNot, cpuPkg::opInc, cpuPkg::opDec, cpuPkg::opAdd,
      cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr: begin
        regWrite = 1'b1;
        updateStatus = 1'b1;
      end
      cpuPkg::opShl, cpuPkg::opShr: begin
        regWrite = 1'b1;
        updateStatus = 1'b1;
        immOrReg = 1'b0;
      end
      cpuPkg::opMov: regWrite = 1'b1;
      cpuPkg::opLdm: begin
        regWrite = 1'b1;
        immOrReg = 1'b0;
      end
      cpuPkg::opIn: begin
        regWrite = 1'b1;
        isIn = 1'b1;
      end
      cpuPkg::opOut: isOut = 1'b1;
      cpuPkg::opLdd: begin
        regWrite = 1'b1;
        memRead = 1'b1;
        memOrReg = 1'b0;
      end
      cpuPkg::opStd: memWrite = 1'b1;
      cpuPkg::opPush: begin
        memWrite = 1'b1;
        spOp = cpuPkg::spPush;
      end
      cpuPkg::opPop: begin
        regWrite = 1'b1;
        memRead = 1'b1;
        memOrReg = 1'b0;
        spOp = cpuPkg::spPop;
      end
      // Branch, call, return and interrupt codes
      default: supported = 1'b0;
    endcase
  end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ns

module registerFile #(
  parameter int dataWidth = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cpuPkg::regAddrWidth-1:0] readAddrA,
  input  logic [cpuPkg::regAddrWidth-1:0] readAddrB,
  output logic [dataWidth-1:0]            readDataA,
  output logic [dataWidth-1:0]            readDataB,
  input  logic                            writeEnable,
  input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
  input  logic [dataWidth-1:0]            writeData
);

  logic [dataWidth-1:0] regs [2**cpuPkg::regAddrWidth];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**cpuPkg::regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Write-through for an instruction two slots behind the writer
  assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
  assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// File: source/decodeStage.sv
`timescale 1ns/1ns

module decodeStage #(
  parameter int dataWidth = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            instrValid,
  input  cpuPkg::opCodeT                  opCode,
  input  logic [cpuPkg::regAddrWidth-1:0] rDst,
  input  logic [cpuPkg::regAddrWidth-1:0] rSrc,
  input  logic [dataWidth-1:0]            imm,
  output logic [cpuPkg::regAddrWidth-1:0] readAddrA,
  output logic [cpuPkg::regAddrWidth-1:0] readAddrB,
  input  logic [dataWidth-1:0]            readDataA,
  input  logic [dataWidth-1:0]            readDataB,
  output logic                            unsupported,
  output logic                            decValid,
  output logic [cpuPkg::regAddrWidth-1:0] decDst,
  output logic [cpuPkg::regAddrWidth-1:0] decSrc,
  output cpuPkg::aluOpT                   decAluOp,
  output logic                            decImmOrReg,
  output logic                            decRegWrite,
  output logic                            decMemRead,
  output logic                            decMemWrite,
  output logic                            decMemOrReg,
  output cpuPkg::spOpT                    decSpOp,
  output logic                            decUpdateStatus,
  output cpuPkg::carrySrcT                decCarrySrc,
  output logic                            decIsOut,
  output logic                            decIsIn,
  output logic [dataWidth-1:0]            decDstData,
  output logic [dataWidth-1:0]            decSrcData,
  output logic [dataWidth-1:0]            decImm
);

  cpuPkg::aluOpT    aluOp;
  cpuPkg::spOpT     spOp;
  cpuPkg::carrySrcT carrySrc;
  logic regWrite, memRead, memWrite, memOrReg;
  logic updateStatus, immOrReg, isOut, isIn, supported;

  controlUnit decoder (.*);

  assign readAddrA = rDst;
  assign readAddrB = rSrc;

  always_ff @(posedge clk) begin
    if (reset) begin
      decValid <= 1'b0;
      unsupported <= 1'b0;
    end else begin
      decValid <= instrValid && supported;
      unsupported <= instrValid && !supported;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      decDst <= rDst;
      decSrc <= rSrc;
      decAluOp <= aluOp;
      decImmOrReg <= immOrReg;
      decRegWrite <= regWrite;
      decMemRead <= memRead;
      decMemWrite <= memWrite;
      decMemOrReg <= memOrReg;
      decSpOp <= spOp;
      decUpdateStatus <= updateStatus;
      decCarrySrc <= carrySrc;
      decIsOut <= isOut;
      decIsIn <= isIn;
      decDstData <= readDataA;
      decSrcData <= readDataB;
      decImm <= imm;
    end
  end

  // Unsupported pulses come only from accepted control transfer codes
  assert property (@(posedge clk) disable iff (reset)
    unsupported |-> $past(instrValid && opCode >= cpuPkg::opJz));

endmodule

// File: source/executeStage.sv
`timescale 1ns/1ns

module executeStage #(
  parameter int dataWidth = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            decValid,
  input  logic [cpuPkg::regAddrWidth-1:0] decDst,
  input  logic [cpuPkg::regAddrWidth-1:0] decSrc,
  input  cpuPkg::aluOpT                   decAluOp,
  input  logic                            decImmOrReg,
  input  logic                            decRegWrite,
  input  logic                            decMemRead,
  input  logic                            decMemWrite,
  input  logic                            decMemOrReg,
  input  cpuPkg::spOpT                    decSpOp,
  input  logic                            decUpdateStatus,
  input  cpuPkg::carrySrcT                decCarrySrc,
  input  logic                            decIsOut,
  input  logic                            decIsIn,
  input  logic [dataWidth-1:0]            decDstData,
  input  logic [dataWidth-1:0]            decSrcData,
  input  logic [dataWidth-1:0]            decImm,
  input  logic [dataWidth-1:0]            inPort,
  input  logic                            fwdEnable,
  input  logic [cpuPkg::regAddrWidth-1:0] fwdAddr,
  input  logic [dataWidth-1:0]            fwdData,
  output logic                            exValid,
  output logic [cpuPkg::regAddrWidth-1:0] exDst,
  output logic                            exRegWrite,
  output logic                            exMemRead,
  output logic                            exMemWrite,
  output logic                            exMemOrReg,
  output cpuPkg::spOpT                    exSpOp,
  output logic                            exIsOut,
  output logic [dataWidth-1:0]            exResult,
  output logic [dataWidth-1:0]            exStoreData,
  output logic                            zeroFlag,
  output logic                            negFlag,
  output logic                            carryFlag
);

  logic [dataWidth-1:0] dstVal, srcVal, operandB, aluResult, result;
  logic [dataWidth:0]   wide;
  logic [3:0]           shiftAmount;
  logic                 aluCarry, carryValid;

  // Forward from the instruction one slot ahead
  assign dstVal = (fwdEnable && fwdAddr == decDst) ? fwdData : decDstData;
  assign srcVal = (fwdEnable && fwdAddr == decSrc) ? fwdData : decSrcData;
  assign operandB = decImmOrReg ? srcVal : decImm;
  assign shiftAmount = decImm[3:0];

  always_comb begin
    wide = '0;
    aluResult = dstVal;
    aluCarry = 1'b0;
    carryValid = 1'b0;
    case (decAluOp)
      cpuPkg::aluAdd: wide = {1'b0, dstVal} + {1'b0, operandB};
      cpuPkg::aluSub: wide = {1'b0, dstVal} - {1'b0, operandB};
      cpuPkg::aluInc: wide = {1'b0, dstVal} + 1'b1;
      cpuPkg::aluDec: wide = {1'b0, dstVal} - 1'b1;
      cpuPkg::aluAnd: aluResult = dstVal & operandB;
      cpuPkg::aluOr: aluResult = dstVal | operandB;
      cpuPkg::aluNot: aluResult = ~dstVal;
      cpuPkg::aluPassImm: aluResult = operandB;
      cpuPkg::aluShl: begin
        wide = {1'b0, srcVal} << shiftAmount;
        aluResult = wide[dataWidth-1:0];
        aluCarry = wide[dataWidth];
        carryValid = 1'b1;
      end
      cpuPkg::aluShr: begin
        // Extra low bit catches the last bit shifted out
        wide = {srcVal, 1'b0} >> shiftAmount;
        aluResult = wide[dataWidth:1];
        aluCarry = wide[0];
        carryValid = 1'b1;
      end
      default: aluResult = dstVal;
    endcase
    if (decAluOp inside {cpuPkg::aluAdd, cpuPkg::aluSub, cpuPkg::aluInc, cpuPkg::aluDec}) begin
      aluResult = wide[dataWidth-1:0];
      aluCarry = wide[dataWidth];
      carryValid = 1'b1;
    end
  end

  assign result = decIsIn ? inPort : aluResult;

  always_ff @(posedge clk) begin
    if (reset) begin
      zeroFlag <= 1'b0;
      negFlag <= 1'b0;
      carryFlag <= 1'b0;
    end else if (decValid && decUpdateStatus) begin
      case (decCarrySrc)
        cpuPkg::carrySet: carryFlag <= 1'b1;
        cpuPkg::carryClear: carryFlag <= 1'b0;
        default: begin
          zeroFlag <= result == '0;
          negFlag <= result[dataWidth-1];
          if (carryValid) begin
            carryFlag <= aluCarry;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exValid <= 1'b0;
    end else begin
      exValid <= decValid;
    end
  end

  always_ff @(posedge clk) begin
    exDst <= decDst;
    exRegWrite <= decRegWrite;
    exMemRead <= decMemRead;
    exMemWrite <= decMemWrite;
    exMemOrReg <= decMemOrReg;
    exSpOp <= decSpOp;
    exIsOut <= decIsOut;
    exResult <= result;
    exStoreData <= srcVal;
  end

endmodule

// File: source/memoryStage.sv
`timescale 1ns/1ns

module memoryStage #(
  parameter int dataWidth = 16,
  parameter int memDepth = 256
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            exValid,
  input  logic [cpuPkg::regAddrWidth-1:0] exDst,
  input  logic                            exRegWrite,
  input  logic                            exMemRead,
  input  logic                            exMemWrite,
  input  logic                            exMemOrReg,
  input  cpuPkg::spOpT                    exSpOp,
  input  logic                            exIsOut,
  input  logic [dataWidth-1:0]            exResult,
  input  logic [dataWidth-1:0]            exStoreData,
  output logic                            writeEnable,
  output logic [cpuPkg::regAddrWidth-1:0] writeAddr,
  output logic [dataWidth-1:0]            writeData,
  output logic                            outValid,
  output logic [dataWidth-1:0]            outData
);

  localparam int addrWidth = $clog2(memDepth);

  logic [dataWidth-1:0] mem [memDepth];
  logic [addrWidth-1:0] stackPtr, memAddr;
  logic [dataWidth-1:0] memData, storeValue;

  // Push writes at the pointer, pop reads one above it
  always_comb begin
    case (exSpOp)
      cpuPkg::spPush: memAddr = stackPtr;
      cpuPkg::spPop: memAddr = stackPtr + 1'b1;
      default: memAddr = exResult[addrWidth-1:0];
    endcase
  end

  assign memData = mem[memAddr];
  assign storeValue = (exSpOp == cpuPkg::spPush) ? exResult : exStoreData;

  assign writeEnable = exValid && exRegWrite;
  assign writeAddr = exDst;
  assign writeData = exMemOrReg ? exResult : memData;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < memDepth; i++) begin
        mem[i] <= '0;
      end
    end else if (exValid && exMemWrite) begin
      mem[memAddr] <= storeValue;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stackPtr <= addrWidth'(memDepth - 1);
      outValid <= 1'b0;
    end else begin
      if (exValid && exSpOp == cpuPkg::spPush) begin
        stackPtr <= stackPtr - 1'b1;
      end else if (exValid && exSpOp == cpuPkg::spPop) begin
        stackPtr <= stackPtr + 1'b1;
      end
      outValid <= exValid && exIsOut;
    end
  end

  always_ff @(posedge clk) begin
    outData <= exResult;
  end

  // The decoder never asks for a read and a write together
  assert property (@(posedge clk) disable iff (reset) exValid |-> !(exMemRead && exMemWrite));

endmodule

// File: source/cpuCore.sv
`timescale 1ns/1ns

module cpuCore #(
  parameter int dataWidth = 16,
  parameter int memDepth = 256
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            instrValid,
  input  cpuPkg::opCodeT                  opCode,
  input  logic [cpuPkg::regAddrWidth-1:0] rDst,
  input  logic [cpuPkg::regAddrWidth-1:0] rSrc,
  input  logic [dataWidth-1:0]            imm,
  input  logic [dataWidth-1:0]            inPort,
  output logic                            outValid,
  output logic [dataWidth-1:0]            outData,
  output logic                            unsupported,
  output logic                            zeroFlag,
  output logic                            negFlag,
  output logic                            carryFlag
);

  logic [cpuPkg::regAddrWidth-1:0] readAddrA, readAddrB, decDst, decSrc, exDst, writeAddr;
  logic [dataWidth-1:0] readDataA, readDataB, decDstData, decSrcData, decImm;
  logic [dataWidth-1:0] exResult, exStoreData, writeData;
  cpuPkg::aluOpT    decAluOp;
  cpuPkg::spOpT     decSpOp, exSpOp;
  cpuPkg::carrySrcT decCarrySrc;
  logic decValid, decImmOrReg, decRegWrite, decMemRead, decMemWrite, decMemOrReg;
  logic decUpdateStatus, decIsOut, decIsIn;
  logic exValid, exRegWrite, exMemRead, exMemWrite, exMemOrReg, exIsOut;
  logic writeEnable;

  decodeStage #(.dataWidth(dataWidth)) decode (.*);

  registerFile #(.dataWidth(dataWidth)) regFile (.*);

  // Write-back bus doubles as the forwarding path
  executeStage #(.dataWidth(dataWidth)) execute (
    .fwdEnable(writeEnable),
    .fwdAddr(writeAddr),
    .fwdData(writeData),
    .*
  );

  memoryStage #(.dataWidth(dataWidth), .memDepth(memDepth)) memory (.*);

endmodule

// File: bench/cpuBench.sv
`timescale 1ns/1ns

module cpuBench;

  localparam int dataWidth = 16;
  localparam int memDepth = 256;
  localparam int regBits = cpuPkg::regAddrWidth;
  localparam int addrBits = $clog2(memDepth);
  localparam int aluCount = 60;
  localparam int flagRounds = 10;
  localparam int inRounds = 8;
  localparam int memRounds = 10;
  localparam int stackOps = 30;
  // Every issue or idle slot of every test, plus margin
  localparam int maxCycles = 4 + (16 + aluCount) + flagRounds * 6 + inRounds * 2
                             + memRounds * 5 + stackOps * 3 + 26 + 50;

  logic clk, reset, instrValid;
  cpuPkg::opCodeT opCode;
  logic [regBits-1:0] rDst, rSrc;
  logic [dataWidth-1:0] imm, inPort, outData;
  logic outValid, unsupported, zeroFlag, negFlag, carryFlag;

  // Model state
  logic [dataWidth-1:0] mRegs [2**regBits];
  logic [dataWidth-1:0] mMem [memDepth];
  logic [addrBits-1:0] mSp;
  logic mZero, mNeg, mCarry;

  logic [dataWidth-1:0] expectOut [$];
  int expectCycle [$];
  string expectTest [$];
  int unsupCycle [$];
  logic [dataWidth-1:0] pendingIn;
  string testName;
  int cycleCount;
  int errors;
  int depth;
  logic [regBits-1:0] ra, rb;

  cpuPkg::opCodeT aluOps [11] = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                                  cpuPkg::opNot, cpuPkg::opInc, cpuPkg::opDec, cpuPkg::opShl,
                                  cpuPkg::opShr, cpuPkg::opMov, cpuPkg::opLdm};

  cpuCore #(.dataWidth(dataWidth), .memDepth(memDepth)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [regBits-1:0] randReg();
    return regBits'($urandom_range(2**regBits - 1));
  endfunction

  function automatic logic [dataWidth-1:0] randWord();
    return dataWidth'($urandom);
  endfunction

  // Executes one instruction on the model, returns the destination value before it
  function automatic logic [dataWidth-1:0] modelStep(input cpuPkg::opCodeT op,
      input logic [regBits-1:0] dst, input logic [regBits-1:0] src,
      input logic [dataWidth-1:0] immVal, input logic [dataWidth-1:0] inVal);
    logic [dataWidth-1:0] a, b, res;
    int amt, sum;
    logic wr, setZn;
    a = mRegs[dst];
    b = mRegs[src];
    amt = int'(immVal[3:0]);
    res = a;
    wr = 1'b0;
    setZn = 1'b0;
    case (op)
      cpuPkg::opSetc: mCarry = 1'b1;
      cpuPkg::opClrc: mCarry = 1'b0;
      cpuPkg::opNot: begin
        res = ~a;
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opInc: begin
        res = a + 1'b1;
        mCarry = a == '1;
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opDec: begin
        res = a - 1'b1;
        mCarry = a == '0;
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opAdd: begin
        sum = int'(a) + int'(b);
        res = a + b;
        mCarry = (sum >> dataWidth) != 0;
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opSub: begin
        res = a - b;
        // Borrow
        mCarry = a < b;
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opAnd: begin
        res = a & b;
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opOr: begin
        res = a | b;
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opShl: begin
        res = b << amt;
        mCarry = (amt == 0) ? 1'b0 : b[dataWidth-amt];
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opShr: begin
        res = b >> amt;
        mCarry = (amt == 0) ? 1'b0 : b[amt-1];
        wr = 1'b1;
        setZn = 1'b1;
      end
      cpuPkg::opMov: begin
        res = b;
        wr = 1'b1;
      end
      cpuPkg::opLdm: begin
        res = immVal;
        wr = 1'b1;
      end
      cpuPkg::opIn: begin
        res = inVal;
        wr = 1'b1;
      end
      cpuPkg::opLdd: begin
        res = mMem[b[addrBits-1:0]];
        wr = 1'b1;
      end
      cpuPkg::opStd: mMem[a[addrBits-1:0]] = b;
      cpuPkg::opPush: begin
        mMem[mSp] = a;
        mSp = mSp - 1'b1;
      end
      cpuPkg::opPop: begin
        mSp = mSp + 1'b1;
        res = mMem[mSp];
        wr = 1'b1;
      end
      default: ;
    endcase
    if (setZn) begin
      mZero = res == '0;
      mNeg = res[dataWidth-1];
    end
    if (wr) begin
      mRegs[dst] = res;
    end
    return a;
  endfunction

  // inPort follows one slot behind, when the IN sits in execute
  task automatic issueInstr(input cpuPkg::opCodeT op, input logic [regBits-1:0] dst,
      input logic [regBits-1:0] src, input logic [dataWidth-1:0] immVal,
      input logic [dataWidth-1:0] inVal);
    logic [dataWidth-1:0] outVal;
    @(negedge clk);
    inPort = pendingIn;
    pendingIn = inVal;
    instrValid = 1'b1;
    opCode = op;
    rDst = dst;
    rSrc = src;
    imm = immVal;
    outVal = modelStep(op, dst, src, immVal, inVal);
    if (op == cpuPkg::opOut) begin
      expectOut.push_back(outVal);
      expectCycle.push_back(cycleCount + 3);
      expectTest.push_back(testName);
    end
    if (op >= cpuPkg::opJz) begin
      unsupCycle.push_back(cycleCount + 1);
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(negedge clk);
      inPort = pendingIn;
      instrValid = 1'b0;
    end
  endtask

  task automatic sendAllRegs();
    for (int r = 0; r < 2**regBits; r++) begin
      issueInstr(cpuPkg::opOut, regBits'(r), '0, '0, '0);
    end
  endtask

  // Outputs are read at the rising edge, before the DUT updates them
  always @(posedge clk) begin : compare
    logic [dataWidth-1:0] expVal;
    int expCyc;
    string name;
    if (outValid) begin
      if (expectOut.size() == 0) begin
        errors++;
        $display("Output %h appeared in cycle %0d with no OUT pending", outData, cycleCount);
      end else begin
        expVal = expectOut.pop_front();
        expCyc = expectCycle.pop_front();
        name = expectTest.pop_front();
        if (outData !== expVal) begin
          errors++;
          $display("Mismatch %s expected %h actual %h", name, expVal, outData);
        end
        if (cycleCount != expCyc) begin
          errors++;
          $display("Output of %s came in cycle %0d, not %0d", name, cycleCount, expCyc);
        end
      end
    end
    if (unsupported) begin
      if (unsupCycle.size() == 0 || unsupCycle[0] != cycleCount) begin
        errors++;
        $display("Unexpected unsupported pulse in cycle %0d", cycleCount);
      end else begin
        void'(unsupCycle.pop_front());
      end
    end
    cycleCount++;
  end

  initial begin : watchdog
    wait (cycleCount >= maxCycles);
    $display("Timeout after %0d cycles, %0d errors so far", cycleCount, errors);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    void'($urandom(76));
    errors = 0;
    cycleCount = 0;
    reset = 1'b1;
    instrValid = 1'b0;
    opCode = cpuPkg::opNop;
    rDst = '0;
    rSrc = '0;
    imm = '0;
    inPort = '0;
    pendingIn = '0;
    for (int i = 0; i < 2**regBits; i++) begin
      mRegs[i] = '0;
    end
    for (int i = 0; i < memDepth; i++) begin
      mMem[i] = '0;
    end
    mSp = addrBits'(memDepth - 1);
    mZero = 1'b0;
    mNeg = 1'b0;
    mCarry = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    testName = "alu";
    for (int r = 0; r < 2**regBits; r++) begin
      issueInstr(cpuPkg::opLdm, regBits'(r), '0, randWord(), '0);
    end
    repeat (aluCount) begin
      issueInstr(aluOps[$urandom_range(10)], randReg(), randReg(), randWord(), '0);
    end
    sendAllRegs();

    testName = "flags";
    repeat (flagRounds) begin
      issueInstr(aluOps[$urandom_range(8)], randReg(), randReg(), randWord(), '0);
      case ($urandom_range(2))
        0: issueInstr(cpuPkg::opSetc, '0, '0, '0, '0);
        1: issueInstr(cpuPkg::opClrc, '0, '0, '0, '0);
        default: issueInstr(cpuPkg::opNop, '0, '0, '0, '0);
      endcase
      idleCycles(4);
      if (zeroFlag !== mZero) begin
        errors++;
        $display("Mismatch %s zero expected %b actual %b", testName, mZero, zeroFlag);
      end
      if (negFlag !== mNeg) begin
        errors++;
        $display("Mismatch %s negative expected %b actual %b", testName, mNeg, negFlag);
      end
      if (carryFlag !== mCarry) begin
        errors++;
        $display("Mismatch %s carry expected %b actual %b", testName, mCarry, carryFlag);
      end
    end

    testName = "in/out";
    repeat (inRounds) begin
      ra = randReg();
      issueInstr(cpuPkg::opIn, ra, '0, '0, randWord());
      issueInstr(cpuPkg::opOut, ra, '0, '0, '0);
    end

    testName = "memory";
    repeat (memRounds) begin
      ra = randReg();
      rb = ra + 1'b1;
      issueInstr(cpuPkg::opLdm, ra, '0, randWord(), '0);
      issueInstr(cpuPkg::opLdm, rb, '0, randWord(), '0);
      issueInstr(cpuPkg::opStd, ra, rb, '0, '0);
      // Load straight after the store to the same address
      ra = randReg();
      issueInstr(cpuPkg::opLdd, ra, rb - 1'b1, '0, '0);
      issueInstr(cpuPkg::opOut, ra, '0, '0, '0);
    end

    testName = "stack";
    depth = 0;
    repeat (stackOps) begin
      if (depth == 0 || $urandom_range(1) == 0) begin
        issueInstr(cpuPkg::opPush, randReg(), '0, '0, '0);
        depth++;
      end else begin
        ra = randReg();
        issueInstr(cpuPkg::opPop, ra, '0, '0, '0);
        issueInstr(cpuPkg::opOut, ra, '0, '0, '0);
        depth--;
      end
    end
    while (depth > 0) begin
      ra = randReg();
      issueInstr(cpuPkg::opPop, ra, '0, '0, '0);
      issueInstr(cpuPkg::opOut, ra, '0, '0, '0);
      depth--;
    end

    testName = "unsupported";
    for (int n = 20; n < 32; n++) begin
      issueInstr(cpuPkg::opCodeT'(n), randReg(), randReg(), randWord(), '0);
    end
    sendAllRegs();
    idleCycles(6);

    if (expectOut.size() != 0) begin
      errors++;
      $display("%0d expected outputs never appeared", expectOut.size());
    end
    if (unsupCycle.size() != 0) begin
      errors++;
      $display("%0d expected unsupported pulses never appeared", unsupCycle.size());
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: list.f
source/cpuPkg.sv
source/controlUnit.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/cpuCore.sv
bench/cpuBench.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpuBench -f list.f -o cpuBench
./obj_dir/cpuBench | tee sim.log
if grep -q "Finished with errors" sim.log; then
  exit 1
fi
exit 0
